/* hw/victim_cache_pkg.sv */
// fixed for 32-bit byte addresses and 64-bit lines; one request in flight at a time

`default_nettype none

package victim_cache_pkg;

    localparam int num_entries     = 16;                  // victim slots
    localparam int entry_idx_width = 4;                   // log2 of num_entries
    localparam int plru_nodes      = num_entries - 1;     // internal nodes of the tree
    localparam int addr_width      = 32;
    localparam int line_width      = 64;
    localparam int offset_width    = 3;                   // byte offset within a line
    localparam int tag_width       = addr_width - offset_width;

    // request from the L1, valid in the cycle request is high
    typedef struct packed {
        logic [addr_width-1:0] miss_addr;   // line the L1 missed on
        logic                  evict_valid; // low for a lookup with nothing to store
        logic                  evict_dirty;
        logic [addr_width-1:0] evict_addr;
        logic [line_width-1:0] evict_data;
    } vc_req_t;

    // response to the L1, valid in the cycle resp is high
    typedef struct packed {
        logic                  found;
        logic                  dirty;       // zero on a miss
        logic [line_width-1:0] data;        // zero on a miss
    } vc_resp_t;

    // one stored slot
    typedef struct packed {
        logic                  valid;
        logic                  dirty;
        logic [tag_width-1:0]  tag;
        logic [line_width-1:0] data;
    } vc_entry_t;

    // writeback of a displaced dirty line
    typedef struct packed {
        logic [addr_width-1:0] addr;        // offset bits are always zero
        logic [line_width-1:0] data;
    } pmem_wr_t;

endpackage

`default_nettype wire

/* hw/plru_tree.sv */
// tree pseudo-LRU over 16 slots; touch_idx must be known when touch is high

`timescale 1ns/10ps
`default_nettype none

module plru_tree
    import victim_cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       touch,     // slot touch_idx was just used
    input  logic [entry_idx_width-1:0] touch_idx,
    output logic [entry_idx_width-1:0] plru_idx   // slot to replace next
);

    logic [plru_nodes-1:0] nodes; // heap order, node 0 is the root

    // heap index of the node at depth d on the way down to slot idx
    // only the upper d bits of idx pick the node, the rest shift away
    function automatic int path_node(logic [entry_idx_width-1:0] idx, int d);
        return (1 << d) - 1 + int'(idx >> (entry_idx_width - d));
    endfunction

    // a node set to 1 sends the victim search to its right subtree,
    // so a touch on the left marks the right side as older
    always_ff @(posedge clk) begin
        if (rst) begin
            nodes <= '0;
        end else if (touch) begin
            for (int d = 0; d < entry_idx_width; d++) begin
                nodes[path_node(touch_idx, d)] <= ~touch_idx[entry_idx_width-1-d];
            end
        end
    end

    // walk from the root, one index bit per level, msb first
    always_comb begin : walk_tree
        logic [entry_idx_width-1:0] idx;
        idx = '0;
        for (int d = 0; d < entry_idx_width; d++) begin
            idx[entry_idx_width-1-d] = nodes[path_node(idx, d)]; // 1 means go right
        end
        plru_idx = idx;
    end

    touch_idx_known: assert property (@(posedge clk) disable iff (rst)
        touch |-> !$isunknown(touch_idx));

endmodule

`default_nettype wire

/* hw/victim_entry_array.sv */
// 16 register slots with one write port; tags of valid slots must stay unique

`timescale 1ns/10ps
`default_nettype none

module victim_entry_array
    import victim_cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic [tag_width-1:0]       lookup_tag,
    input  logic [entry_idx_width-1:0] sel_idx,      // read select for victim_entry
    input  logic                       wr_en,
    input  logic [entry_idx_width-1:0] wr_idx,
    input  vc_entry_t                  wr_entry,
    output logic                       hit,
    output logic [entry_idx_width-1:0] hit_idx,
    output vc_entry_t                  hit_entry,
    output logic                       free_valid,   // at least one slot is empty
    output logic [entry_idx_width-1:0] free_idx,     // lowest empty slot
    output vc_entry_t                  victim_entry
);

    logic [num_entries-1:0] valid_q;
    logic [num_entries-1:0] dirty_q;
    logic [tag_width-1:0]   tag_q  [num_entries];
    logic [line_width-1:0]  data_q [num_entries];

    logic [num_entries-1:0] match;     // per-slot hit on lookup_tag
    logic [num_entries-1:0] wr_clash;  // another valid slot already holds wr_entry.tag

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= wr_entry.valid; // a zero entry invalidates the slot
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            dirty_q[wr_idx] <= wr_entry.dirty;
            tag_q[wr_idx]   <= wr_entry.tag;
            data_q[wr_idx]  <= wr_entry.data;
        end
    end

    // parallel compare against every slot
    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            match[i]    = valid_q[i] && (tag_q[i] == lookup_tag);
            wr_clash[i] = valid_q[i] && (tag_q[i] == wr_entry.tag) && (i != int'(wr_idx));
        end
    end

    // priority encoders, scanning down so the lowest index wins
    always_comb begin
        hit_idx  = '0;
        free_idx = '0;
        for (int i = num_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit_idx = entry_idx_width'(i);
            end
            if (!valid_q[i]) begin
                free_idx = entry_idx_width'(i);
            end
        end
    end

    assign hit        = |match;
    assign free_valid = ~&valid_q;

    assign hit_entry = {valid_q[hit_idx], dirty_q[hit_idx], tag_q[hit_idx], data_q[hit_idx]};
    assign victim_entry = {valid_q[sel_idx], dirty_q[sel_idx], tag_q[sel_idx], data_q[sel_idx]};

    // a line may live in at most one slot, so a lookup never sees two matches
    unique_tag_on_write: assert property (@(posedge clk) disable iff (rst)
        wr_en && wr_entry.valid |-> wr_clash == '0);

endmodule

`default_nettype wire

/* hw/victim_cache_ctrl.sv */
// single outstanding request; the L1 must not send another request before resp

`timescale 1ns/10ps
`default_nettype none

module victim_cache_ctrl
    import victim_cache_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       request,
    input  vc_req_t                    req,
    input  logic                       pmem_resp,
    input  logic                       hit,
    input  logic [entry_idx_width-1:0] hit_idx,
    input  vc_entry_t                  hit_entry,
    input  logic                       free_valid,
    input  logic [entry_idx_width-1:0] free_idx,
    input  logic [entry_idx_width-1:0] plru_idx,
    input  vc_entry_t                  victim_entry,
    output logic [tag_width-1:0]       lookup_tag,
    output logic [entry_idx_width-1:0] sel_idx,
    output logic                       wr_en,
    output logic [entry_idx_width-1:0] wr_idx,
    output vc_entry_t                  wr_entry,
    output logic                       touch,
    output logic [entry_idx_width-1:0] touch_idx,
    output logic                       resp,
    output vc_resp_t                   rsp,
    output logic                       pmem_write,
    output pmem_wr_t                   pmem_wr
);

    typedef enum logic {
        idle,
        write_back
    } ctrl_state_e;

    ctrl_state_e                state;
    ctrl_state_e                next_state;
    logic                       accept;    // request taken this cycle
    logic                       need_wb;   // displaced line must go to memory first
    logic [entry_idx_width-1:0] slot_idx;  // slot written and touched for this request
    vc_entry_t                  new_entry;

    assign lookup_tag = req.miss_addr[addr_width-1:offset_width];
    assign accept     = request && (state == idle);

    // hit slot first, then the lowest empty slot, then the tree's choice
    always_comb begin
        if (hit) begin
            slot_idx = hit_idx;
        end else if (free_valid) begin
            slot_idx = free_idx;
        end else begin
            slot_idx = plru_idx;
        end
    end

    assign sel_idx = slot_idx; // victim_entry follows the chosen slot

    // empty request stores a zero entry, which invalidates a hit slot
    always_comb begin
        new_entry = '0;
        if (req.evict_valid) begin
            new_entry.valid = 1'b1;
            new_entry.dirty = req.evict_dirty;
            new_entry.tag   = req.evict_addr[addr_width-1:offset_width];
            new_entry.data  = req.evict_data;
        end
    end

    assign need_wb = !hit && req.evict_valid && !free_valid
                     && victim_entry.valid && victim_entry.dirty;

    assign wr_en     = accept && (req.evict_valid || hit);
    assign wr_idx    = slot_idx;
    assign wr_entry  = new_entry;
    assign touch     = accept;   // every accepted request counts as a use
    assign touch_idx = slot_idx;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (accept && need_wb) begin
                    next_state = write_back;
                end
            end
            write_back: begin
                if (pmem_resp) begin
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            resp  <= 1'b0;
        end else begin
            state <= next_state;
            resp  <= (accept && !need_wb) || ((state == write_back) && pmem_resp);
        end
    end

    // rsp holds through a writeback until resp
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp.found <= hit;
            rsp.dirty <= hit && hit_entry.dirty;
            rsp.data  <= hit ? hit_entry.data : '0;
        end
        if (accept && need_wb) begin
            pmem_wr.addr <= {victim_entry.tag, {offset_width{1'b0}}};
            pmem_wr.data <= victim_entry.data;
        end
    end

    assign pmem_write = (state == write_back); // held until the pmem_resp cycle

    no_request_in_write_back: assert property (@(posedge clk) disable iff (rst)
        state == write_back |-> !request);

    pmem_wr_held: assert property (@(posedge clk) disable iff (rst)
        pmem_write && !pmem_resp |=> $stable(pmem_wr));

endmodule

`default_nettype wire

/* hw/victim_cache_top.sv */
// 16-entry victim cache; no read fills, one request outstanding, pmem_write held to pmem_resp

`timescale 1ns/10ps
`default_nettype none

module victim_cache_top
    import victim_cache_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     request,     // one-cycle pulse from the L1
    input  vc_req_t  req,
    input  logic     pmem_resp,   // memory accepted the writeback
    output logic     resp,        // one-cycle pulse, rsp valid with it
    output vc_resp_t rsp,
    output logic     pmem_write,
    output pmem_wr_t pmem_wr
);

    logic [tag_width-1:0]       lookup_tag;
    logic [entry_idx_width-1:0] sel_idx;
    logic                       wr_en;
    logic [entry_idx_width-1:0] wr_idx;
    vc_entry_t                  wr_entry;
    logic                       hit;
    logic [entry_idx_width-1:0] hit_idx;
    vc_entry_t                  hit_entry;
    logic                       free_valid;
    logic [entry_idx_width-1:0] free_idx;
    vc_entry_t                  victim_entry;
    logic                       touch;
    logic [entry_idx_width-1:0] touch_idx;
    logic [entry_idx_width-1:0] plru_idx;

    victim_cache_ctrl victim_cache_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .request      (request),
        .req          (req),
        .pmem_resp    (pmem_resp),
        .hit          (hit),
        .hit_idx      (hit_idx),
        .hit_entry    (hit_entry),
        .free_valid   (free_valid),
        .free_idx     (free_idx),
        .plru_idx     (plru_idx),
        .victim_entry (victim_entry),
        .lookup_tag   (lookup_tag),
        .sel_idx      (sel_idx),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_entry     (wr_entry),
        .touch        (touch),
        .touch_idx    (touch_idx),
        .resp         (resp),
        .rsp          (rsp),
        .pmem_write   (pmem_write),
        .pmem_wr      (pmem_wr)
    );

    victim_entry_array victim_entry_array_i (
        .clk          (clk),
        .rst          (rst),
        .lookup_tag   (lookup_tag),
        .sel_idx      (sel_idx),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .wr_entry     (wr_entry),
        .hit          (hit),
        .hit_idx      (hit_idx),
        .hit_entry    (hit_entry),
        .free_valid   (free_valid),
        .free_idx     (free_idx),
        .victim_entry (victim_entry)
    );

    plru_tree plru_tree_i (
        .clk       (clk),
        .rst       (rst),
        .touch     (touch),
        .touch_idx (touch_idx),
        .plru_idx  (plru_idx)
    );

endmodule

`default_nettype wire

/* tb/victim_cache_tb.sv */
// needs tb/victim_cache_testdata.txt relative to the run directory; memory answers after 0 to 7 cycles

`timescale 1ns/10ps
`default_nettype none

module victim_cache_tb
    import victim_cache_pkg::*;
();

    typedef struct packed {
        logic     do_reset;   // pulse rst before this request
        vc_req_t  req;
        vc_resp_t exp_rsp;
        logic     exp_wb;     // a writeback must come before resp
        pmem_wr_t exp_wr;
    } test_vec_t;

    logic      clk;
    logic      rst;
    logic      request;
    vc_req_t   req;
    logic      pmem_resp;
    logic      resp;
    vc_resp_t  rsp;
    logic      pmem_write;
    pmem_wr_t  pmem_wr;
    test_vec_t vectors[$];
    int        errors = 0;
    int        failed_tests = 0;
    int        cycles = 0;
    int        cycle_limit = 100;

    victim_cache_top victim_cache_top_i (
        .clk        (clk),
        .rst        (rst),
        .request    (request),
        .req        (req),
        .pmem_resp  (pmem_resp),
        .resp       (resp),
        .rsp        (rsp),
        .pmem_write (pmem_write),
        .pmem_wr    (pmem_wr)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic note_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic load_vectors();
        int          fd;
        int          fields;
        string       line;
        logic        do_reset;
        logic        evict_valid;
        logic        evict_dirty;
        logic        found;
        logic        dirty;
        logic        wb;
        logic [31:0] miss_addr;
        logic [31:0] evict_addr;
        logic [31:0] wb_addr;
        logic [63:0] evict_data;
        logic [63:0] data;
        logic [63:0] wb_data;
        test_vec_t   v;
        fd = $fopen("tb/victim_cache_testdata.txt", "r");
        if (fd == 0) begin
            note_failure("could not open tb/victim_cache_testdata.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h", do_reset, miss_addr,
                             evict_valid, evict_dirty, evict_addr, evict_data, found, dirty,
                             data, wb, wb_addr, wb_data);
            if (fields <= 0) begin
                continue; // blank line
            end
            if (fields != 12) begin
                note_failure($sformatf("test data line has %0d fields instead of 12", fields));
                continue;
            end
            v = {do_reset, miss_addr, evict_valid, evict_dirty, evict_addr, evict_data,
                 found, dirty, data, wb, wb_addr, wb_data};
            vectors.push_back(v);
        end
        $fclose(fd);
    endtask

    // one memory cycle of a pending writeback, address and data must not move
    task automatic check_writeback(input pmem_wr_t expected);
        check_value("pmem_write", 1'b1, pmem_write);
        check_value("pmem_wr.addr", expected.addr, pmem_wr.addr);
        check_value("pmem_wr.data", expected.data, pmem_wr.data);
        check_value("resp", 1'b0, resp);
    endtask

    // bring the DUT back to idle after a missing resp, answering any writeback
    task automatic wait_for_resp();
        int n;
        n = 0;
        while (resp !== 1'b1 && n < 16) begin
            pmem_resp = pmem_write;
            @(negedge clk);
            pmem_resp = 1'b0;
            n++;
        end
    endtask

    task automatic run_vector(input int num, input test_vec_t v);
        int errors_before;
        int delay;
        errors_before = errors;
        if (v.do_reset) begin
            rst = 1'b1;
            repeat (5) @(negedge clk);
            rst = 1'b0;
        end
        request = 1'b1;
        req     = v.req;
        @(negedge clk);
        request = 1'b0;
        req     = '0;
        if (v.exp_wb) begin
            check_writeback(v.exp_wr);
            delay = $urandom % 8; // memory latency
            repeat (delay) begin
                @(negedge clk);
                check_writeback(v.exp_wr);
            end
            pmem_resp = 1'b1;
            @(negedge clk);
            pmem_resp = 1'b0;
        end
        if (resp !== 1'b1) begin
            note_failure($sformatf("test %0d: resp did not come in the expected cycle", num));
            wait_for_resp();
        end else begin
            check_value("rsp.found", v.exp_rsp.found, rsp.found);
            check_value("rsp.dirty", v.exp_rsp.dirty, rsp.dirty);
            check_value("rsp.data", v.exp_rsp.data, rsp.data);
            check_value("pmem_write", 1'b0, pmem_write);
            @(negedge clk);
            check_value("resp", 1'b0, resp); // resp is a one-cycle pulse
        end
        if (errors == errors_before) begin
            $display("test %0d: ok", num);
        end else begin
            $display("test %0d: failed", num);
            failed_tests++;
        end
    endtask

    initial begin : main
        void'($urandom(42706));
        rst       = 1'b1;
        request   = 1'b0;
        req       = '0;
        pmem_resp = 1'b0;
        load_vectors();
        if (vectors.size() == 0) begin
            note_failure("no test vectors were read");
        end
        cycle_limit = vectors.size() * 12 + 100;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        foreach (vectors[i]) begin
            run_vector(i, vectors[i]);
        end
        $display("%0d tests run, %0d failed, %0d errors", vectors.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/victim_cache_testdata.txt */
# reset miss_addr evict_valid evict_dirty evict_addr evict_data found dirty data wb wb_addr wb_data
# all fields hex; reset 1 pulses rst for 5 cycles before the request
0 00080000 1 0 00001000 d000000000000000 0 0 0000000000000000 0 00000000 0000000000000000
0 00080008 1 0 00001040 d000000000000001 0 0 0000000000000000 0 00000000 0000000000000000
0 00080010 1 0 00001080 d000000000000002 0 0 0000000000000000 0 00000000 0000000000000000
0 00080018 1 0 000010c0 d000000000000003 0 0 0000000000000000 0 00000000 0000000000000000
0 00080020 1 0 00001100 d000000000000004 0 0 0000000000000000 0 00000000 0000000000000000
0 00080028 1 0 00001140 d000000000000005 0 0 0000000000000000 0 00000000 0000000000000000
0 00080030 1 0 00001180 d000000000000006 0 0 0000000000000000 0 00000000 0000000000000000
0 00080038 1 0 000011c0 d000000000000007 0 0 0000000000000000 0 00000000 0000000000000000
0 00080040 1 0 00001200 d000000000000008 0 0 0000000000000000 0 00000000 0000000000000000
0 00080048 1 0 00001240 d000000000000009 0 0 0000000000000000 0 00000000 0000000000000000
0 00080050 1 0 00001280 d00000000000000a 0 0 0000000000000000 0 00000000 0000000000000000
0 00080058 1 0 000012c0 d00000000000000b 0 0 0000000000000000 0 00000000 0000000000000000
0 00080060 1 0 00001300 d00000000000000c 0 0 0000000000000000 0 00000000 0000000000000000
0 00080068 1 0 00001340 d00000000000000d 0 0 0000000000000000 0 00000000 0000000000000000
0 00080070 1 0 00001380 d00000000000000e 0 0 0000000000000000 0 00000000 0000000000000000
0 00080078 1 0 000013c0 d00000000000000f 0 0 0000000000000000 0 00000000 0000000000000000
0 00001140 1 1 00002000 a1a1a1a1a1a1a1a1 1 0 d000000000000005 0 00000000 0000000000000000
0 00002000 1 1 00002040 a2a2a2a2a2a2a2a2 1 1 a1a1a1a1a1a1a1a1 0 00000000 0000000000000000
0 00003000 1 0 00002080 a3a3a3a3a3a3a3a3 0 0 0000000000000000 0 00000000 0000000000000000
0 00002080 1 0 000020c0 a4a4a4a4a4a4a4a4 1 0 a3a3a3a3a3a3a3a3 0 00000000 0000000000000000
0 00001200 0 0 00000000 0000000000000000 0 0 0000000000000000 0 00000000 0000000000000000
0 00001100 1 0 00002100 a5a5a5a5a5a5a5a5 1 0 d000000000000004 0 00000000 0000000000000000
0 00001180 1 0 00002140 a6a6a6a6a6a6a6a6 1 0 d000000000000006 0 00000000 0000000000000000
0 00001080 1 0 00002180 a7a7a7a7a7a7a7a7 1 0 d000000000000002 0 00000000 0000000000000000
0 000020c0 1 0 000021c0 a8a8a8a8a8a8a8a8 1 0 a4a4a4a4a4a4a4a4 0 00000000 0000000000000000
0 00004000 1 1 00002200 a9a9a9a9a9a9a9a9 0 0 0000000000000000 1 00002040 a2a2a2a2a2a2a2a2
0 00002200 0 0 00000000 0000000000000000 1 1 a9a9a9a9a9a9a9a9 0 00000000 0000000000000000
0 00002200 0 0 00000000 0000000000000000 0 0 0000000000000000 0 00000000 0000000000000000
0 00002040 1 0 00002240 b0b0b0b0b0b0b0b0 0 0 0000000000000000 0 00000000 0000000000000000
1 00001000 1 0 00002280 b1b1b1b1b1b1b1b1 0 0 0000000000000000 0 00000000 0000000000000000
0 00002280 0 0 00000000 0000000000000000 1 0 b1b1b1b1b1b1b1b1 0 00000000 0000000000000000

/* all.f */
hw/victim_cache_pkg.sv
hw/plru_tree.sv
hw/victim_entry_array.sv
hw/victim_cache_ctrl.sv
hw/victim_cache_top.sv
tb/victim_cache_tb.sv

/* Bender.yml */
package:
  name: victim_cache

sources:
  - files:
      - hw/victim_cache_pkg.sv
      - hw/plru_tree.sv
      - hw/victim_entry_array.sv
      - hw/victim_cache_ctrl.sv
      - hw/victim_cache_top.sv
  - target: test
    files:
      - tb/victim_cache_tb.sv
